/* rtl/prefetch_consts.svh */
// sizes are block-address based; ALMOST_FULL_LEVEL must not exceed QUEUE_DEPTH, limits need at least 1
`ifndef PREFETCH_CONSTS_SVH
`define PREFETCH_CONSTS_SVH

`define ADDR_BITS 32         // byte address width
`define BLOCK_BITS 6         // 64-byte blocks

`define QUEUE_DEPTH 8        // prefetch queue entries
`define ALMOST_FULL_LEVEL 6  // issue stops at this occupancy

// prefetches sent to memory and not yet completed
`define OUTSTAND_LIMIT 4

`endif

/* rtl/prefetchPkg.sv */
// types only; widths follow the macros in prefetch_consts.svh, strides wrap modulo the block space
`default_nettype none

`include "prefetch_consts.svh"

package prefetchPkg;

    typedef logic [`ADDR_BITS-1:0] addrT;                       // byte address
    typedef logic [`ADDR_BITS-`BLOCK_BITS-1:0] blockAddrT;      // block address

    // signed so that descending streams work
    typedef logic signed [`ADDR_BITS-`BLOCK_BITS-1:0] strideT;

    typedef logic [$clog2(`QUEUE_DEPTH+1)-1:0] occT;            // 0..QUEUE_DEPTH
    typedef logic [$clog2(`OUTSTAND_LIMIT+1)-1:0] outCntT;      // 0..OUTSTAND_LIMIT

    typedef enum logic [1:0] {
        sIdle,   // no history yet
        sArm,    // one block seen, waiting for a stride
        sActive  // stride locked, prefetching
    } strideStateT;

endpackage

`default_nettype wire

/* rtl/strideIf.sv */
// plain strobes and levels, no handshake; back-pressure levels already include the push in flight
`timescale 1ns/1ps
`default_nettype none

interface strideIf;
    import prefetchPkg::*;

    logic pfValid;          // one-cycle prefetch strobe
    blockAddrT pfAddr;      // block to prefetch
    logic flushN;           // one-cycle low pulse on a stride break
    logic almostFull;       // queue nearly full
    logic outstandingFull;  // memory has as many prefetches as it may take

    modport ctrl (
        output pfValid, pfAddr, flushN,
        input  almostFull, outstandingFull
    );

    modport queue (
        input  pfValid, pfAddr, flushN,
        output almostFull, outstandingFull
    );

endinterface

`default_nettype wire

/* rtl/reqRangeFilter.sv */
// one register stage; bar and limit are inclusive byte addresses, en low holds the block and drops reqValid
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module reqRangeFilter (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  en,
    input  logic                  rdValid,
    input  prefetchPkg::addrT     rdAddr,
    input  prefetchPkg::addrT     bar,
    input  prefetchPkg::addrT     limit,
    output logic                  reqValid,
    output prefetchPkg::blockAddrT reqBlock
);
    import prefetchPkg::*;

    logic inWindow;
    blockAddrT rdBlock;

    // window check is on the full byte address, before alignment
    assign inWindow = (rdAddr >= bar) && (rdAddr <= limit);
    assign rdBlock = rdAddr[`ADDR_BITS-1:`BLOCK_BITS];  // drop the offset bits

    // a held strobe would repeat the same read downstream, so it falls while disabled
    always_ff @(posedge clk) begin
        if (!resetN) begin
            reqValid <= 1'b0;
        end else begin
            reqValid <= en && rdValid && inWindow;
        end
    end

    always_ff @(posedge clk) begin
        if (en && rdValid) begin
            reqBlock <= rdBlock;
        end
    end

endmodule

`default_nettype wire

/* rtl/prefetcherCtrl.sv */
// degree-one stride detector; dropped prefetches are not retried, en low drops the strobes and holds state
`timescale 1ns/1ps
`default_nettype none

module prefetcherCtrl (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   en,
    input  logic                   reqValid,
    input  prefetchPkg::blockAddrT reqBlock,
    strideIf.ctrl                  pf
);
    import prefetchPkg::*;

    strideStateT state, nxtState;
    blockAddrT lastBlock;
    blockAddrT nxtPfAddr;
    strideT storedStride, nxtStride;
    strideT curStride;
    logic strideMatch;
    logic backPressure;
    logic nxtPfValid, nxtFlushN;

    // block difference read as two's complement, so negative strides come out right
    assign curStride = strideT'(reqBlock - lastBlock);
    assign strideMatch = (curStride == storedStride);
    assign backPressure = pf.almostFull || pf.outstandingFull;

    always_comb begin
        nxtState = state;
        nxtStride = storedStride;
        nxtPfValid = 1'b0;
        nxtFlushN = 1'b1;
        nxtPfAddr = pf.pfAddr;

        if (reqValid) begin
            unique case (state)
                sIdle: begin
                    nxtState = sArm;  // first block only sets lastBlock
                end
                sArm: begin
                    if (curStride != '0) begin
                        nxtState = sActive;
                        nxtStride = curStride;
                    end
                end
                sActive: begin
                    if (strideMatch) begin
                        // address is computed even when the issue gets dropped
                        nxtPfAddr = reqBlock + blockAddrT'(storedStride);
                        nxtPfValid = !backPressure;
                    end else if (curStride != '0) begin
                        // stride broke, so the queued blocks are stale
                        nxtFlushN = 1'b0;
                        nxtStride = curStride;  // kept as the new candidate
                        nxtState = sArm;
                    end
                    // zero stride means a repeated block, nothing changes
                end
                default: begin
                    nxtState = sIdle;
                end
            endcase
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (!resetN) begin
            state <= sIdle;
            pf.pfValid <= 1'b0;
            pf.flushN <= 1'b1;
        end else begin
            pf.pfValid <= en && nxtPfValid;   // pulses never stretch while disabled
            pf.flushN <= !en || nxtFlushN;
            if (en) begin
                state <= nxtState;
            end
        end
    end

    // history and address registers
    always_ff @(posedge clk) begin
        if (en) begin
            if (reqValid) begin
                lastBlock <= reqBlock;
            end
            storedStride <= nxtStride;
            pf.pfAddr <= nxtPfAddr;
        end
    end

endmodule

`default_nettype wire

/* rtl/prefetchQueue.sv */
// holds block addresses only; flush beats push, outstanding count survives a flush, not gated by en
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module prefetchQueue (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   reqValid,
    input  prefetchPkg::blockAddrT reqBlock,
    input  logic                   memDone,
    strideIf.queue                 pf,
    output logic                   hitValid,
    output prefetchPkg::occT       occupancy
);
    import prefetchPkg::*;

    localparam int PTR_BITS = $clog2(`QUEUE_DEPTH);

    blockAddrT mem [`QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wrPtr, rdPtr;
    occT count, nxtCount;
    outCntT outCnt, nxtOutCnt;
    logic push, pop, headHit;

    function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
        nextPtr = (ptr == PTR_BITS'(`QUEUE_DEPTH-1)) ? '0 : ptr + 1'b1;
    endfunction

    assign headHit = reqValid && (count != '0) && (reqBlock == mem[rdPtr]);
    assign pop = headHit;
    assign push = pf.pfValid && (count != occT'(`QUEUE_DEPTH));  // full guard

    always_comb begin
        nxtCount = count;
        if (!pf.flushN) begin
            nxtCount = '0;
        end else if (push && !pop) begin
            nxtCount = count + 1'b1;
        end else if (pop && !push) begin
            nxtCount = count - 1'b1;
        end
    end

    // memory completions and new issues cancel out when they coincide
    always_comb begin
        nxtOutCnt = outCnt;
        if (pf.pfValid && !memDone) begin
            nxtOutCnt = outCnt + 1'b1;
        end else if (memDone && !pf.pfValid && (outCnt != '0)) begin
            nxtOutCnt = outCnt - 1'b1;
        end
    end

    // levels look one edge ahead so an issue already on pfValid is counted
    assign pf.almostFull = (nxtCount >= occT'(`ALMOST_FULL_LEVEL));
    assign pf.outstandingFull = (nxtOutCnt == outCntT'(`OUTSTAND_LIMIT));
    assign occupancy = count;

    always_ff @(posedge clk) begin
        if (!resetN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
            outCnt <= '0;
            hitValid <= 1'b0;
        end else begin
            count <= nxtCount;
            outCnt <= nxtOutCnt;
            hitValid <= headHit;  // a hit is still reported in a flush cycle
            if (!pf.flushN) begin
                wrPtr <= '0;
                rdPtr <= '0;
            end else begin
                if (push) wrPtr <= nextPtr(wrPtr);
                if (pop) rdPtr <= nextPtr(rdPtr);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && pf.flushN) begin
            mem[wrPtr] <= pf.pfAddr;
        end
    end

endmodule

`default_nettype wire

/* rtl/prefetcherTop.sv */
// prefetches appear two cycles after their demand read; memDone must only pulse for issued prefetches
`timescale 1ns/1ps
`default_nettype none

module prefetcherTop (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   en,
    input  logic                   rdValid,
    input  prefetchPkg::addrT      rdAddr,
    input  prefetchPkg::addrT      bar,
    input  prefetchPkg::addrT      limit,
    input  logic                   memDone,
    output logic                   pfIssueValid,
    output prefetchPkg::blockAddrT pfIssueAddr,
    output logic                   flushN,
    output logic                   hitValid,
    output prefetchPkg::occT       occupancy
);
    import prefetchPkg::*;

    logic reqValid;
    blockAddrT reqBlock;

    strideIf pfBus ();

    reqRangeFilter u_reqRangeFilter (
        .clk      (clk),
        .resetN   (resetN),
        .en       (en),
        .rdValid  (rdValid),
        .rdAddr   (rdAddr),
        .bar      (bar),
        .limit    (limit),
        .reqValid (reqValid),
        .reqBlock (reqBlock)
    );

    prefetcherCtrl u_prefetcherCtrl (
        .clk      (clk),
        .resetN   (resetN),
        .en       (en),
        .reqValid (reqValid),
        .reqBlock (reqBlock),
        .pf       (pfBus.ctrl)
    );

    prefetchQueue u_prefetchQueue (
        .clk       (clk),
        .resetN    (resetN),
        .reqValid  (reqValid),
        .reqBlock  (reqBlock),
        .memDone   (memDone),
        .pf        (pfBus.queue),
        .hitValid  (hitValid),
        .occupancy (occupancy)
    );

    assign pfIssueValid = pfBus.pfValid;
    assign pfIssueAddr = pfBus.pfAddr;
    assign flushN = pfBus.flushN;

endmodule

`default_nettype wire

/* verif/prefetcher_props.sv */
// bound into prefetchQueue; relies on its internal count and outCnt names, en held high in the testbench
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module prefetcherProps (
    input wire logic clk,
    input wire logic resetN,
    input wire logic pfValid,
    input wire logic almostFull,
    input wire logic flushN,
    input wire prefetchPkg::occT count,
    input wire prefetchPkg::outCntT outCnt
);
    occBound: assert property (@(posedge clk) disable iff (!resetN) count <= `QUEUE_DEPTH)
        else $error("queue occupancy above depth");
    // the level seen when the controller decided blocks the strobe one cycle later
    noIssueWhenFull: assert property (@(posedge clk) disable iff (!resetN)
        $past(almostFull) |-> !pfValid) else $error("prefetch issued while almost full");
    outBound: assert property (@(posedge clk) disable iff (!resetN) outCnt <= `OUTSTAND_LIMIT)
        else $error("outstanding count above limit");
    flushOneCycle: assert property (@(posedge clk) disable iff (!resetN) !flushN |=> flushN)
        else $error("flush held low for more than one cycle");
endmodule

bind prefetchQueue prefetcherProps u_props (
    .clk(clk), .resetN(resetN), .pfValid(pf.pfValid), .almostFull(pf.almostFull),
    .flushN(pf.flushN), .count(count), .outCnt(outCnt)
);

`default_nettype wire

/* verif/prefetcherTb.sv */
// cycle model of the stride rules checked every falling edge; en stays high, window is fixed
`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module prefetcherTb;
    import prefetchPkg::*;

    localparam int RAND_READS = 200;
    localparam int STIM_CYCLES = 6 * 8 + 16 * 2 + 24 * 3 + 20 * 3 + 20 * 3 + 30 + RAND_READS * 4;
    localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 200;  // margin for test tails

    logic clk = 0, resetN = 0, en = 0, rdValid = 0, memDone = 0;
    addrT rdAddr = '0, bar = 32'h0001_0000, limit = 32'h0004_FFFF;
    logic pfIssueValid, flushN, hitValid;
    blockAddrT pfIssueAddr;
    occT occupancy;

    integer seed = 95692;
    int cycleCount = 0, errCount = 0, errTotal = 0, testsFailed = 0, testsRun = 0;
    int issueCount = 0, flushCount = 0, hitCount = 0, maxOcc = 0;
    logic memRandom = 0;
    string curTest = "reset";

    // model registers
    strideStateT mState;
    strideT mStride;
    blockAddrT mLast, mReqBlock, mPfAddr, modelQ[$];
    logic mReqValid, mPfValid, mFlushN, mHit;
    int mOut;

    prefetcherTop u_prefetcherTop (.*);

    always #4 clk = ~clk;

    // stride rule for one in-range request
    function automatic void refPrefetch(input strideStateT st, input strideT strd,
            input blockAddrT last, input blockAddrT blk, input logic bp,
            output strideStateT nSt, output strideT nStrd, output logic issue,
            output blockAddrT addr, output logic flushLow);
        strideT cur;
        cur = strideT'(blk - last);
        nSt = st;
        nStrd = strd;
        issue = 0;
        flushLow = 0;
        addr = blk + blockAddrT'(strd);
        if (st == sIdle) nSt = sArm;
        else if (st == sArm && cur != 0) begin
            nSt = sActive;
            nStrd = cur;
        end else if (st == sActive && cur == strd) issue = !bp;
        else if (st == sActive && cur != 0) begin
            flushLow = 1;
            nStrd = cur;
            nSt = sArm;
        end
    endfunction

    always @(posedge clk) begin
        int nCount, qSize;
        logic pushNow, popNow, issue, flushLow;
        blockAddrT addr;
        strideStateT nSt;
        strideT nStrd;
        qSize = modelQ.size();
        if (!resetN) begin
            mState = sIdle;
            mStride = 0;
            mLast = 0;
            mReqValid = 0;
            mPfValid = 0;
            mFlushN = 1;
            mHit = 0;
            mOut = 0;
            modelQ.delete();
        end else begin
            pushNow = mPfValid && qSize != `QUEUE_DEPTH;
            popNow = mReqValid && qSize != 0 && mReqBlock == modelQ[0];
            nCount = !mFlushN ? 0 : qSize + pushNow - popNow;
            if (mPfValid && !memDone) mOut++;
            else if (memDone && !mPfValid && mOut != 0) mOut--;
            if (!mFlushN) modelQ.delete();
            else begin
                if (popNow) void'(modelQ.pop_front());
                if (pushNow) modelQ.push_back(mPfAddr);
            end
            mHit = popNow;
            mPfValid = 0;
            mFlushN = 1;
            if (mReqValid) begin
                refPrefetch(mState, mStride, mLast, mReqBlock,
                    nCount >= `ALMOST_FULL_LEVEL || mOut == `OUTSTAND_LIMIT,
                    nSt, nStrd, issue, addr, flushLow);
                mState = nSt;
                mStride = nStrd;
                mPfValid = issue;
                mFlushN = !flushLow;
                if (issue) mPfAddr = addr;
                mLast = mReqBlock;
            end
            mReqValid = en && rdValid && rdAddr >= bar && rdAddr <= limit;
            if (en && rdValid) mReqBlock = rdAddr[`ADDR_BITS-1:`BLOCK_BITS];
        end
    end

    task automatic report(input string what, input longint exp, input longint act);
        $display("mismatch %s %s expected %0h actual %0h", curTest, what, exp, act);
        errCount++;
    endtask

    // outputs have settled by the falling edge
    always @(negedge clk) begin
        if (resetN) begin
            assert (pfIssueValid === mPfValid) else report("pfIssueValid", mPfValid, pfIssueValid);
            if (mPfValid) assert (pfIssueAddr === mPfAddr)
                else report("pfIssueAddr", mPfAddr, pfIssueAddr);
            assert (flushN === mFlushN) else report("flushN", mFlushN, flushN);
            assert (hitValid === mHit) else report("hitValid", mHit, hitValid);
            assert (occupancy === occT'(modelQ.size()))
                else report("occupancy", modelQ.size(), occupancy);
            issueCount += pfIssueValid;
            flushCount += !flushN;
            hitCount += hitValid;
            if (occupancy > maxOcc) maxOcc = occupancy;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic startTest(input string name);
        curTest = name;
        @(negedge clk) resetN <= 0;
        repeat (3) @(negedge clk);
        resetN <= 1;
        errCount = 0;
        issueCount = 0;
        flushCount = 0;
        hitCount = 0;
        maxOcc = 0;
    endtask

    // lets the last reads reach the outputs before the counts are judged
    task automatic drainPipeline();
        repeat (6) @(negedge clk) rdValid <= 0;
    endtask

    task automatic endTest(input logic extraOk, input string why);
        assert (extraOk) else begin
            $display("%s: %s", curTest, why);
            errCount++;
        end
        $display("test %s: %0d errors", curTest, errCount);
        testsRun++;
        errTotal += errCount;
        if (errCount != 0) testsFailed++;
    endtask

    task automatic readAt(input addrT a, input int gap);
        @(negedge clk);
        rdValid <= 1;
        rdAddr <= a;
        memDone <= memRandom && ($random(seed) & 1);
        repeat (gap) @(negedge clk) begin
            rdValid <= 0;
            memDone <= memRandom && ($random(seed) & 1);
        end
    endtask

    // n reads starting at a with a stride of strd blocks
    task automatic stream(input addrT a, input int strd, input int n, input int gap);
        for (int i = 0; i < n; i++) readAt(a + addrT'(i * strd * 64), gap);
    endtask

    initial begin
        en = 1;
        memRandom = 1;
        startTest("outOfRange");
        stream(32'h0010_0000, 1, 8, 1);
        stream(32'h0000_0100, 2, 8, 1);
        drainPipeline();
        endTest(issueCount == 0 && hitCount == 0 && flushCount == 0, "activity outside window");
        startTest("strideStreams");
        stream(32'h0001_0000, 3, 12, 2);
        stream(32'h0004_0000, -2, 12, 2);
        drainPipeline();
        endTest(issueCount >= 18, "too few prefetches on constant strides");
        startTest("strideChange");
        stream(32'h0002_0000, 1, 5, 2);
        stream(32'h0002_0140, 4, 5, 2);
        drainPipeline();
        endTest(flushCount == 1, "flushN did not pulse exactly once");
        startTest("headHit");
        stream(32'h0003_0000, 2, 8, 2);
        drainPipeline();
        endTest(hitCount > 0, "no hit on the oldest prefetch");
        startTest("outstandingLimit");
        memRandom = 0;
        stream(32'h0001_0000, 1, 10, 2);
        assert (issueCount == `OUTSTAND_LIMIT) else begin
            $display("outstandingLimit: issue did not stop at the limit");
            errCount++;
        end
        memRandom = 1;
        stream(32'h0001_0280, 1, 10, 2);
        drainPipeline();
        endTest(issueCount > `OUTSTAND_LIMIT, "issue did not resume after memDone");
        startTest("almostFullRandom");
        stream(32'h0002_0000, 1, 20, 0);  // back-to-back reads never hit the head
        for (int i = 0; i < RAND_READS; i += 5)
            stream(bar + addrT'($random(seed) & 32'h3_FFFF), $random(seed) % 3, 5,
                $random(seed) & 3);
        drainPipeline();
        endTest(maxOcc == `ALMOST_FULL_LEVEL, "occupancy did not stop at the almost-full level");
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errTotal);
        if (errTotal == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* src.f */
+incdir+rtl
rtl/prefetchPkg.sv
rtl/strideIf.sv
rtl/reqRangeFilter.sv
rtl/prefetcherCtrl.sv
rtl/prefetchQueue.sv
rtl/prefetcherTop.sv
verif/prefetcher_props.sv
verif/prefetcherTb.sv

/* runSim.sh */
#!/bin/sh
# builds and runs the prefetcher testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module prefetcherTb -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
